// ==== files.f ====
+incdir+logic
logic/vmask_op_pkg.sv
logic/vmask_bus_pkg.sv
logic/credit_fifo.sv
logic/element_classifier.sv
logic/mask_logic_unit.sv
logic/element_merge.sv
logic/egress_credit_port.sv
logic/vector_mask_unit.sv
test/vmask_asserts.sv
test/tb_vector_mask_unit.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f files.f --top-module tb_vector_mask_unit \
    && ./obj_dir/Vtb_vector_mask_unit +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== test/tb_vector_mask_unit.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module tb_vector_mask_unit;

    localparam int NUM_TXN        = 96;                  // 8 ops x 4 sews, three rounds
    localparam int TIMEOUT_CYCLES = 20 * NUM_TXN + 200;
    localparam int IDX_W          = `VMASK_IDX_W;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      in_valid;
    vmask_bus_pkg::vmask_req_t in_req;
    logic                      out_credit;
    logic                      in_credit;
    logic                      out_valid;
    vmask_bus_pkg::vmask_res_t out_res;

    logic [31:0]               rng_state = 32'h4be8;  // xorshift state
    vmask_bus_pkg::vmask_res_t exp_q [$];             // expected, in request order
    int                        up_credits;            // sender's ingress credits
    int                        rx_held;               // receiver slots in use
    int                        hold_cycles;           // stretch of withheld credits
    int                        sent;
    int                        received;
    int                        cycle_cnt = 0;

    vector_mask_unit DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

    always #2 clk = ~clk;   // 4 ns period

    //////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // opcode order vmand .. vmxnor, a is vs2, b is vs1
    function automatic logic [15:0] mask_op_ref(input logic [2:0] op, input logic [15:0] a,
                                                input logic [15:0] b);
        case (op)
            3'd0:    return a & b;
            3'd1:    return ~(a & b);
            3'd2:    return a & ~b;
            3'd3:    return a ^ b;
            3'd4:    return a | b;
            3'd5:    return ~(a | b);
            3'd6:    return a | ~b;
            default: return ~(a ^ b);
        endcase
    endfunction

    function automatic vmask_bus_pkg::vmask_res_t expected_res(input vmask_bus_pkg::vmask_req_t r);
        vmask_bus_pkg::vmask_res_t e;
        logic [15:0]               eff;
        int                        sew_bits;
        int                        idx;
        e.mask_result = mask_op_ref(r.mask_op, r.vs2, r.vs1);
        eff           = r.mask_reg_en ? e.mask_result : r.v0;
        sew_bits      = 8 << r.sew;
        for (int j = 0; j < `VMASK_VLEN; j++) begin
            idx = j / sew_bits;                                      // element holding bit j
            if (!r.mask_en) e.data[j] = r.lanes_data[j];
            else if (idx >= int'(r.vl)) e.data[j] = r.vta ? 1'b1 : r.dest_data[j];
            else if (idx < int'(r.vstart)) e.data[j] = r.dest_data[j];
            else if (eff[idx]) e.data[j] = r.lanes_data[j];
            else e.data[j] = r.vma ? 1'b1 : r.dest_data[j];
        end
        return e;
    endfunction

    function automatic vmask_bus_pkg::vmask_req_t build_req(input int n);
        vmask_bus_pkg::vmask_req_t r;
        logic [31:0]               bits;
        int                        elems;
        for (int k = 0; k < 4; k++) begin
            r.lanes_data[k*32 +: 32] = next_rand();
            r.dest_data[k*32 +: 32]  = next_rand();
        end
        bits          = next_rand();
        r.v0          = bits[15:0];
        r.vs1         = bits[31:16];
        bits          = next_rand();
        r.vs2         = bits[15:0];
        r.mask_op     = vmask_op_pkg::mask_op_e'(3'(n % 8));        // walks all opcodes
        r.sew         = vmask_op_pkg::sew_e'(2'((n / 8) % 4));
        elems         = `VMASK_ELEMS >> r.sew;
        case (n % 6)
            0:       r.vl = '0;                                    // all tail
            1:       r.vl = IDX_W'(elems);                         // no tail
            default: r.vl = IDX_W'(bits[20:16] % (elems + 1));
        endcase
        r.vstart      = (n % 6 == 2) ? '0 : IDX_W'(bits[25:21] % (elems + 1));
        r.vta         = bits[26];
        r.vma         = bits[27];
        r.mask_reg_en = bits[28];
        r.mask_en     = (n % 5 != 4);                              // every fifth unmasked
        return r;
    endfunction

    //////////////////////////////////////////////////
    // per-cycle tasks, all run on the falling edge
    //////////////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_outputs();
        vmask_bus_pkg::vmask_res_t want;
        if (out_valid) begin
            assert (exp_q.size() != 0)
                else fail_now("out_valid fired with no request outstanding");
            want = exp_q.pop_front();
            assert (out_res.mask_result == want.mask_result)
                else fail_now($sformatf("** Error: out_res.mask_result = %h, expected %h",
                                        out_res.mask_result, want.mask_result));
            assert (out_res.data == want.data)
                else fail_now($sformatf("** Error: out_res.data = %h, expected %h",
                                        out_res.data, want.data));
            received++;
            rx_held++;                                             // lands in a receiver slot
        end
        assert (rx_held <= `VMASK_OUT_CREDITS)
            else fail_now("receiver got more results than it had free slots");
        assert (!DUT.u_asserts.failed)
            else fail_now("a protocol assertion bound to the DUT fired");
    endtask

    task automatic return_credits();
        logic [31:0] bits;
        bits = next_rand();
        if (hold_cycles == 0 && bits[4:0] == 5'd0) hold_cycles = 8 + int'(bits[9:5]);
        if (hold_cycles > 0) begin
            hold_cycles--;                                         // downstream stalled
            out_credit = 1'b0;
        end else if (rx_held > 0 && bits[10]) begin
            out_credit = 1'b1;
            rx_held--;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic drive_request();
        vmask_bus_pkg::vmask_req_t req;
        logic [31:0]               bits;
        bits = next_rand();
        if (sent < NUM_TXN && up_credits > 0 && bits[1:0] != 2'b00) begin
            req      = build_req(sent);
            in_req   = req;
            in_valid = 1'b1;
            exp_q.push_back(expected_res(req));
            up_credits--;
            sent++;
        end else begin
            in_valid = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout after %0d cycles, only %0d of %0d results came back",
                               cycle_cnt, received, NUM_TXN));
        end
    end

    initial begin
        logic credit_back;
        in_valid    = 1'b0;
        in_req      = '0;
        out_credit  = 1'b0;
        rst_n       = 1'b0;
        up_credits  = `VMASK_Q_DEPTH;
        rx_held     = 0;
        hold_cycles = 0;
        sent        = 0;
        received    = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (6) begin                                           // idle, outputs stay low
            @(negedge clk);
            check_outputs();
            assert (!in_credit)
                else fail_now("in_credit pulsed before any request was sent");
        end
        while (sent < NUM_TXN || exp_q.size() != 0) begin
            @(negedge clk);
            credit_back = in_credit;
            check_outputs();
            return_credits();
            drive_request();
            if (credit_back) up_credits++;                         // spendable from next cycle
            assert (up_credits <= `VMASK_Q_DEPTH)
                else fail_now("upstream got back more credits than it spent");
        end
        assert (up_credits == `VMASK_Q_DEPTH)
            else fail_now($sformatf("** Error: up_credits = %h, expected %h",
                                    up_credits, `VMASK_Q_DEPTH));
        @(negedge clk);                                            // bound checks see last result
        if (DUT.u_asserts.failed || out_valid) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "run ended with a protocol failure or an extra result");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== test/vmask_asserts.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module vmask_asserts (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);

    int   accepted;                  // requests sitting in the ingress queue
    int   avail;                     // downstream credits as seen on the pins
    int   pending;                   // past ingress, not yet sent
    logic fail_out_credit = 1'b0;
    logic fail_in_credit  = 1'b0;
    logic fail_order      = 1'b0;
    logic fail_reset      = 1'b0;
    logic failed;                    // any check fired, watched by the testbench

    assign failed = fail_out_credit | fail_in_credit | fail_order | fail_reset;

    //////////////////////////////////////////////////
    // shadow counters from the port pins
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accepted <= 0;
            avail    <= `VMASK_OUT_CREDITS;
            pending  <= 0;
        end else begin
            accepted <= accepted + int'(in_valid) - int'(in_credit);
            avail    <= avail + int'(out_credit) - int'(out_valid);   // returned usable next cycle
            pending  <= pending + int'(in_credit) - int'(out_valid);
        end
    end

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////

    a_out_credit: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> avail > 0)
        else begin
            fail_out_credit = 1'b1;
            $error("out_valid fired with no downstream credit left");
        end

    a_in_credit: assert property (@(posedge clk) disable iff (!rst_n) in_credit |-> accepted > 0)
        else begin
            fail_in_credit = 1'b1;
            $error("in_credit returned with no accepted request inside");
        end

    a_order: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> pending > 0)
        else begin
            fail_order = 1'b1;
            $error("out_valid fired with no result past the ingress queue");
        end

    // outputs quiet while reset is held
    a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid && !in_credit)
        else begin
            fail_reset = 1'b1;
            $error("out_valid or in_credit high during reset");
        end

endmodule

bind vector_mask_unit vmask_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

// ==== logic/vector_mask_unit.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module vector_mask_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,   // upstream spends one credit
    input  vmask_bus_pkg::vmask_req_t in_req,
    input  logic                      out_credit, // downstream returns one slot
    output logic                      in_credit,  // request left ingress queue
    output logic                      out_valid,
    output vmask_bus_pkg::vmask_res_t out_res
);

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    logic                      req_head_valid;
    vmask_bus_pkg::vmask_req_t req_head;       // request under evaluation
    vmask_bus_pkg::region_t    region;         // prestart/body/tail labels
    logic [`VMASK_ELEMS-1:0]   mask_result;    // op result
    logic [`VMASK_ELEMS-1:0]   eff_mask;       // mask used by merge
    vmask_bus_pkg::vmask_res_t merge_res;      // combinational result
    logic                      res_full;       // result queue back-pressure
    logic                      res_head_valid;
    vmask_bus_pkg::vmask_res_t res_head;
    logic                      res_head_ready; // egress pops result queue

    //////////////////////////////////////////////////
    // ingress queue
    //////////////////////////////////////////////////

    credit_fifo #(.payload_t(vmask_bus_pkg::vmask_req_t)) u_req_q (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (in_valid),
        .push_data     (in_req),
        .head_ready    (~res_full),       // advance when result queue has room
        .head_valid    (req_head_valid),
        .head_data     (req_head),
        .full          (),                // upstream credits keep it from overflowing
        .credit_return (in_credit)
    );

    //////////////////////////////////////////////////
    // datapath, all combinational on the ingress head
    //////////////////////////////////////////////////

    element_classifier u_classifier (
        .vstart (req_head.vstart),
        .vl     (req_head.vl),
        .region (region)
    );

    mask_logic_unit u_mask_logic (
        .vs1         (req_head.vs1),
        .vs2         (req_head.vs2),
        .v0          (req_head.v0),
        .mask_op     (req_head.mask_op),
        .mask_reg_en (req_head.mask_reg_en),
        .mask_result (mask_result),
        .eff_mask    (eff_mask)
    );

    element_merge u_merge (
        .req         (req_head),
        .region      (region),
        .eff_mask    (eff_mask),
        .mask_result (mask_result),
        .res         (merge_res)
    );

    //////////////////////////////////////////////////
    // result queue and egress
    //////////////////////////////////////////////////

    credit_fifo #(.payload_t(vmask_bus_pkg::vmask_res_t)) u_res_q (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (req_head_valid),  // dropped inside when full, head then stalls
        .push_data     (merge_res),
        .head_ready    (res_head_ready),
        .head_valid    (res_head_valid),
        .head_data     (res_head),
        .full          (res_full),
        .credit_return ()                 // egress tracks downstream credits itself
    );

    egress_credit_port u_egress (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (res_head_valid),
        .head_data  (res_head),
        .out_credit (out_credit),
        .head_ready (res_head_ready),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

endmodule

// ==== logic/egress_credit_port.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module egress_credit_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      head_valid,  // result queue has an entry
    input  vmask_bus_pkg::vmask_res_t head_data,
    input  logic                      out_credit,  // downstream freed a slot
    output logic                      head_ready,  // pop the result queue
    output logic                      out_valid,
    output vmask_bus_pkg::vmask_res_t out_res
);

    localparam int CREDIT_W = `VMASK_CREDIT_W;

    logic [CREDIT_W-1:0] credits;   // downstream slots we may still fill
    logic                send;      // result goes out this cycle

    assign send       = head_valid && (credits != '0);
    assign out_valid  = send;
    assign head_ready = send;       // only pop what is sent
    assign out_res    = head_data;  // no staging, straight from queue head

    //////////////////////////////////////////////////
    // downstream credit counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(`VMASK_OUT_CREDITS);
        end else begin
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1; // returned, usable next cycle
                2'b01:   credits <= credits - 1'b1; // spent
                default: credits <= credits;        // both cancel or idle
            endcase
        end
    end

endmodule

// ==== logic/element_merge.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module element_merge (
    input  vmask_bus_pkg::vmask_req_t req,
    input  vmask_bus_pkg::region_t    region,
    input  logic [`VMASK_ELEMS-1:0]   eff_mask,
    input  logic [`VMASK_ELEMS-1:0]   mask_result,
    output vmask_bus_pkg::vmask_res_t res
);

    localparam int VLEN   = `VMASK_VLEN;
    localparam int N_SEWS = 4;               // e8, e16, e32, e64

    logic [N_SEWS-1:0][VLEN-1:0] merged;     // one candidate per width
    logic [VLEN-1:0]             sel_data;   // candidate for req.sew

    //////////////////////////////////////////////////
    // per-width, per-element merge
    //////////////////////////////////////////////////

    for (genvar w = 0; w < N_SEWS; w++) begin : g_sew
        localparam int SEW = 8 << w;         // element bits
        localparam int N   = VLEN / SEW;     // elements in one register

        for (genvar e = 0; e < N; e++) begin : g_elem
            logic [SEW-1:0] lane;
            logic [SEW-1:0] dest;
            logic [SEW-1:0] elem;

            assign lane = req.lanes_data[e*SEW +: SEW];
            assign dest = req.dest_data[e*SEW +: SEW];

            always_comb begin
                if (region.prestart[e]) begin
                    elem = dest;                        // untouched before vstart
                end else if (region.body[e]) begin
                    if (eff_mask[e]) begin
                        elem = lane;                    // active, take lane result
                    end else if (req.vma) begin
                        elem = '1;                      // masked off, agnostic fill
                    end else begin
                        elem = dest;                    // masked off, undisturbed
                    end
                end else if (region.tail[e] && req.vta) begin
                    elem = '1;                          // tail agnostic fill
                end else begin
                    elem = dest;                        // tail undisturbed
                end
            end

            assign merged[w][e*SEW +: SEW] = elem;
        end
    end

    //////////////////////////////////////////////////
    // width select and output
    //////////////////////////////////////////////////

    assign sel_data = merged[req.sew];       // sew code indexes the candidates

    always_comb begin
        res.mask_result = mask_result;       // mask leaves as its own field
        if (req.mask_en) begin
            res.data = sel_data;
        end else begin
            res.data = req.lanes_data;       // unmasked op, lanes pass straight
        end
    end

endmodule

// ==== logic/mask_logic_unit.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module mask_logic_unit (
    input  logic [`VMASK_ELEMS-1:0] vs1,
    input  logic [`VMASK_ELEMS-1:0] vs2,
    input  logic [`VMASK_ELEMS-1:0] v0,
    input  vmask_op_pkg::mask_op_e  mask_op,
    input  logic                    mask_reg_en,  // use op result as mask
    output logic [`VMASK_ELEMS-1:0] mask_result,  // op result, always reported
    output logic [`VMASK_ELEMS-1:0] eff_mask      // mask applied in merge
);

    //////////////////////////////////////////////////
    // mask-logical ops, bitwise on vs2 and vs1
    //////////////////////////////////////////////////

    always_comb begin
        case (mask_op)
            vmask_op_pkg::OP_VMAND:  mask_result = vs2 & vs1;
            vmask_op_pkg::OP_VMNAND: mask_result = ~(vs2 & vs1);
            vmask_op_pkg::OP_VMANDN: mask_result = vs2 & ~vs1;
            vmask_op_pkg::OP_VMXOR:  mask_result = vs2 ^ vs1;
            vmask_op_pkg::OP_VMOR:   mask_result = vs2 | vs1;
            vmask_op_pkg::OP_VMNOR:  mask_result = ~(vs2 | vs1);
            vmask_op_pkg::OP_VMORN:  mask_result = vs2 | ~vs1;
            vmask_op_pkg::OP_VMXNOR: mask_result = ~(vs2 ^ vs1);
            default:                 mask_result = vs2 & vs1; // unreachable, all codes used
        endcase
    end

    //////////////////////////////////////////////////
    // effective mask select
    //////////////////////////////////////////////////

    always_comb begin
        if (mask_reg_en) begin
            eff_mask = mask_result;  // freshly computed mask
        end else begin
            eff_mask = v0;           // architectural v0
        end
    end

endmodule

// ==== logic/element_classifier.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module element_classifier (
    input  logic [`VMASK_IDX_W-1:0] vstart,
    input  logic [`VMASK_IDX_W-1:0] vl,
    output vmask_bus_pkg::region_t  region
);

    localparam int IDX_W = `VMASK_IDX_W;
    localparam int ELEMS = `VMASK_ELEMS;

    //////////////////////////////////////////////////
    // per-index region compare
    //////////////////////////////////////////////////

    // tail takes priority, so with vstart >= vl
    // indices at or past vl are tail and only those below vl can be prestart
    always_comb begin
        region = '0;
        for (int i = 0; i < ELEMS; i++) begin
            if (IDX_W'(i) >= vl) begin
                region.tail[i] = 1'b1;          // at or beyond vl
            end else if (IDX_W'(i) < vstart) begin
                region.prestart[i] = 1'b1;      // already done before a trap
            end else begin
                region.body[i] = 1'b1;          // active element
            end
        end
    end

endmodule

// ==== logic/credit_fifo.sv ====
`timescale 1ns/1ps
`include "vmask_defs.svh"

module credit_fifo #(
    parameter type payload_t = logic // entry type, request or result
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,          // write side strobe
    input  payload_t push_data,
    input  logic     head_ready,    // consumer takes head this cycle
    output logic     head_valid,    // head entry present
    output payload_t head_data,
    output logic     full,
    output logic     credit_return  // one pulse per departing entry
);

    localparam int DEPTH = `VMASK_Q_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];   // circular buffer
    logic [PTR_W-1:0] wr_ptr;        // next free slot
    logic [PTR_W-1:0] rd_ptr;        // current head
    logic [PTR_W:0]   count;         // occupancy 0..DEPTH
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;            // writes into a full queue are dropped
    assign do_pop  = head_valid && head_ready; // entry leaves

    assign full          = (count == (PTR_W + 1)'(DEPTH));
    assign head_valid    = (count != '0);
    assign head_data     = mem[rd_ptr];
    assign credit_return = do_pop;             // freed slot goes back upstream

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== logic/vmask_bus_pkg.sv ====
`include "vmask_defs.svh"

package vmask_bus_pkg;

    //////////////////////////////////////////////////
    // request into the mask stage
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`VMASK_VLEN-1:0]   lanes_data;  // results coming back from the lanes
        logic [`VMASK_VLEN-1:0]   dest_data;   // current destination register contents
        logic [`VMASK_ELEMS-1:0]  v0;          // architectural mask register
        logic [`VMASK_ELEMS-1:0]  vs1;         // mask operand 1
        logic [`VMASK_ELEMS-1:0]  vs2;         // mask operand 2
        vmask_op_pkg::mask_op_e   mask_op;     // which mask-logical op
        vmask_op_pkg::sew_e       sew;         // element width code
        logic [`VMASK_IDX_W-1:0]  vstart;      // first body element
        logic [`VMASK_IDX_W-1:0]  vl;          // first tail element
        logic                     vta;         // tail agnostic
        logic                     vma;         // mask agnostic
        logic                     mask_en;     // vm = 0, masking active
        logic                     mask_reg_en; // mask from op result instead of v0
    } vmask_req_t;

    //////////////////////////////////////////////////
    // result out of the mask stage
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`VMASK_VLEN-1:0]  data;        // merged register value
        logic [`VMASK_ELEMS-1:0] mask_result; // mask-logical op result
    } vmask_res_t;

    // one-hot per element index, exactly one field set per bit
    typedef struct packed {
        logic [`VMASK_ELEMS-1:0] prestart; // i < vstart
        logic [`VMASK_ELEMS-1:0] body;     // vstart <= i < vl
        logic [`VMASK_ELEMS-1:0] tail;     // i >= vl
    } region_t;

endpackage

// ==== logic/vmask_op_pkg.sv ====
package vmask_op_pkg;

    //////////////////////////////////////////////////
    // element width
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        E8  = 2'd0, // 16 elements per register
        E16 = 2'd1, // 8 elements
        E32 = 2'd2, // 4 elements
        E64 = 2'd3  // 2 elements
    } sew_e;

    //////////////////////////////////////////////////
    // mask-logical opcodes, operands vs2 op vs1
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_VMAND  = 3'd0, // vs2 & vs1
        OP_VMNAND = 3'd1, // ~(vs2 & vs1)
        OP_VMANDN = 3'd2, // vs2 & ~vs1
        OP_VMXOR  = 3'd3, // vs2 ^ vs1
        OP_VMOR   = 3'd4, // vs2 | vs1
        OP_VMNOR  = 3'd5, // ~(vs2 | vs1)
        OP_VMORN  = 3'd6, // vs2 | ~vs1
        OP_VMXNOR = 3'd7  // ~(vs2 ^ vs1)
    } mask_op_e;

endpackage

// ==== logic/vmask_defs.svh ====
`ifndef VMASK_DEFS_SVH
`define VMASK_DEFS_SVH

//////////////////////////////////////////////////
// datapath sizing
//////////////////////////////////////////////////

`define VMASK_VLEN        128 // vector register width in bits
`define VMASK_ELEMS       16  // max element count at sew 8, also mask width
`define VMASK_IDX_W       5   // vstart / vl width, covers 0..16

//////////////////////////////////////////////////
// flow control
//////////////////////////////////////////////////

`define VMASK_Q_DEPTH     4   // queue depth, upstream starts with this many credits
`define VMASK_OUT_CREDITS 4   // downstream slots at reset
`define VMASK_CREDIT_W    3   // holds 0..VMASK_OUT_CREDITS

`endif
